//--- hdl/dyn_trg_pkg.sv
// ####################
// shared widths, constants and types for the dynode readout channel
// word counts include the closing energy word
// mode and channel encodings follow the coincidence controller
// ####################
package dyn_trg_pkg;

	localparam int ADC_W            = 8;   // raw adc sample
	localparam int CORR_W           = 12;  // baseline-corrected sample and energy
	localparam int WORD_W           = 16;  // fifo word
	localparam int TIME_W           = 24;  // event time stamp
	localparam int SAMPLE_FIX_DELAY = 8;   // fixed stages ahead of the tap line
	localparam int TAP_MAX          = 15;  // deepest programmable tap
	localparam int FIFO_DEPTH       = 64;
	localparam int FIFO_NEARLY_FULL = 48;
	localparam int PTR_W            = $clog2(FIFO_DEPTH);
	localparam int CNT_W            = 6;   // frame word down-counter

	localparam logic [WORD_W-1:0] PREAMBLE       = 16'hA5A5;
	localparam logic [7:0]        TRIG_IDLE_CODE = 8'hFF;  // no event this clock
	localparam logic [7:0]        TRIG_WRAP_CODE = 8'hF8;  // time about to wrap

	typedef enum logic [1:0] {
		MODE_ENERGY     = 2'b00,  // energy word only
		MODE_RAW        = 2'b01,  // 32 raw samples
		MODE_CORR_LONG  = 2'b10,  // 32 corrected samples
		MODE_CORR_SHORT = 2'b11   // 16 corrected samples
	} data_mode_e;

	typedef enum logic [2:0] {
		ST_IDLE     = 3'd0,
		ST_PREAMBLE = 3'd1,
		ST_NWORDS   = 3'd2,
		ST_MASK     = 3'd3,
		ST_DATA     = 3'd4
	} frame_state_e;

	typedef struct packed {
		logic [ADC_W-1:0]  raw;
		logic [CORR_W-1:0] corr;
	} adc_in_t;

	typedef struct packed {
		logic              flag;   // event seen this clock
		logic [TIME_W-1:0] etime;
	} event_in_t;

	typedef struct packed {
		logic              load;   // corrected energy ready
		logic [CORR_W-1:0] value;
	} energy_in_t;

	typedef struct packed {
		data_mode_e mode;
		logic [1:0] channel;
		logic [3:0] tap;
	} readout_cfg_t;

	typedef struct packed {
		logic              wen;
		logic [WORD_W-1:0] data;
	} fifo_wr_t;

	// record word count after the mask, samples plus energy
	function automatic logic [CNT_W-1:0] mode_nwords(data_mode_e mode);
		case (mode)
			MODE_ENERGY:    return CNT_W'(1);
			MODE_RAW:       return CNT_W'(33);
			MODE_CORR_LONG: return CNT_W'(33);
			default:        return CNT_W'(17);
		endcase
	endfunction

endpackage

//--- hdl/sample_delay.sv
// ####################
// sample source select plus fixed and tapped delay
// mode and tap must hold still during a frame
// delay contents are junk until the line has filled
// ####################
module sample_delay (
	input  logic                           clk,
	input  dyn_trg_pkg::adc_in_t           adc,
	input  dyn_trg_pkg::data_mode_e        mode,
	input  logic [3:0]                     tap,
	output logic [dyn_trg_pkg::WORD_W-1:0] sample_word
);
	import dyn_trg_pkg::*;

	logic [CORR_W-1:0] sel_sample;                   // raw or corrected pick
	logic [CORR_W-1:0] fix_dly [SAMPLE_FIX_DELAY];   // fixed pipeline
	logic [CORR_W-1:0] tap_dly [TAP_MAX+1];          // programmable line
	logic [CORR_W-1:0] tap_sample;

	// raw only in raw mode, everything else wants the corrected sample
	always_comb begin
		if (mode == MODE_RAW) begin
			sel_sample = {{(CORR_W-ADC_W){1'b0}}, adc.raw};  // zero-extend byte
		end else begin
			sel_sample = adc.corr;
		end
	end

	always_ff @(posedge clk) begin
		fix_dly[0] <= sel_sample;  // stage 0 registers the pick
		for (int i = 1; i < SAMPLE_FIX_DELAY; i++) begin
			fix_dly[i] <= fix_dly[i-1];
		end
	end

	always_ff @(posedge clk) begin
		tap_dly[0] <= fix_dly[SAMPLE_FIX_DELAY-1];  // one more stage past fixed line
		for (int i = 1; i <= TAP_MAX; i++) begin
			tap_dly[i] <= tap_dly[i-1];
		end
	end

	// tap read straight off the line registers
	// total age here is fixed + 1 + tap clocks
	always_comb begin
		tap_sample  = tap_dly[tap];
		sample_word = {{(WORD_W-CORR_W){1'b0}}, tap_sample};
	end

endmodule

//--- hdl/event_capture.sv
// ####################
// coincidence trigger code, energy latch, frame start
// energy latch follows every load, even mid-frame
// start requests are ignored while a frame runs
// ####################
module event_capture (
	input  logic                           clk,
	input  logic                           rst,
	input  dyn_trg_pkg::event_in_t         evt,
	input  dyn_trg_pkg::energy_in_t        energy,
	input  logic                           trigger,
	input  logic                           frame_busy,
	output logic [7:0]                     trigger_code,
	output logic                           frame_start,
	output logic [dyn_trg_pkg::WORD_W-1:0] energy_word
);
	import dyn_trg_pkg::*;

	logic start_req;
	logic time_wrap;

	// frame_start itself blocks a second pulse,
	// frame_busy only rises the clock after it
	assign start_req = (energy.load | trigger) & ~frame_busy & ~frame_start;
	assign time_wrap = &evt.etime[11:6];  // coarse time near rollover

	always_ff @(posedge clk) begin
		if (rst) begin
			trigger_code <= TRIG_IDLE_CODE;
		end else if (!evt.flag) begin
			trigger_code <= TRIG_IDLE_CODE;  // idle between events
		end else if (time_wrap) begin
			trigger_code <= TRIG_WRAP_CODE;
		end else begin
			trigger_code <= evt.etime[11:4];  // coarse time bits
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			frame_start <= 1'b0;
		end else begin
			frame_start <= start_req;  // single clock strobe
		end
	end

	always_ff @(posedge clk) begin
		if (energy.load) begin
			energy_word <= {{(WORD_W-CORR_W){1'b0}}, energy.value};
		end
	end

endmodule

//--- hdl/frame_builder.sv
// ####################
// record framer, one fifo word per clock
// record is preamble, count, mask, samples, energy
// no back-pressure, words are pushed blind
// cfg must stay put while busy
// ####################
module frame_builder (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           frame_start,
	input  dyn_trg_pkg::readout_cfg_t      cfg,
	input  logic [dyn_trg_pkg::WORD_W-1:0] sample_word,
	input  logic [dyn_trg_pkg::WORD_W-1:0] energy_word,
	output logic                           frame_busy,
	output dyn_trg_pkg::fifo_wr_t          wr
);
	import dyn_trg_pkg::*;

	frame_state_e      state;
	logic [CNT_W-1:0]  count;       // words left after the mask
	logic [CNT_W-1:0]  nwords_cnt;  // count for the current mode
	logic [WORD_W-1:0] nwords;      // same, as a record word
	logic [WORD_W-1:0] mask;        // one-hot channel

	always_comb begin
		nwords_cnt = mode_nwords(cfg.mode);
		nwords     = {{(WORD_W-CNT_W){1'b0}}, nwords_cnt};
		mask       = '0;
		mask[cfg.channel] = 1'b1;
	end

	// busy covers the last write, the fsm leaves data one clock after it
	assign frame_busy = (state != ST_IDLE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= ST_IDLE;
			count  <= '0;
			wr.wen <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					wr.wen <= 1'b0;
					count  <= nwords_cnt;  // reload every idle clock
					if (frame_start) begin
						state <= ST_PREAMBLE;
					end
				end
				ST_PREAMBLE: begin
					wr.data <= PREAMBLE;
					wr.wen  <= 1'b1;
					state   <= ST_NWORDS;
				end
				ST_NWORDS: begin
					wr.data <= nwords;
					wr.wen  <= 1'b1;
					state   <= ST_MASK;
				end
				ST_MASK: begin
					wr.data <= mask;
					wr.wen  <= 1'b1;
					state   <= ST_DATA;
				end
				ST_DATA: begin
					if (count == '0) begin
						wr.wen <= 1'b0;  // energy word already out
						state  <= ST_IDLE;
					end else if (count == CNT_W'(1)) begin
						wr.data <= energy_word;  // closing word
						wr.wen  <= 1'b1;
						count   <= count - CNT_W'(1);
					end else begin
						wr.data <= sample_word;
						wr.wen  <= 1'b1;
						count   <= count - CNT_W'(1);
					end
				end
				default: begin
					wr.wen <= 1'b0;  // stray code, back to idle
					state  <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hdl/trigger_fifo.sv
// ####################
// 64 word show-ahead fifo for readout records
// writes into a full fifo are lost
// q is only meaningful while nempty is high
// ####################
module trigger_fifo (
	input  logic                           clk,
	input  logic                           rst,
	input  dyn_trg_pkg::fifo_wr_t          wr,
	input  logic                           ren,
	output logic [dyn_trg_pkg::WORD_W-1:0] q,
	output logic                           nempty,
	output logic                           nearly_full
);
	import dyn_trg_pkg::*;

	logic [WORD_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W:0]    count;  // one extra bit to hold full
	logic              push;
	logic              pop;
	logic              full;

	assign full        = (count == (PTR_W+1)'(FIFO_DEPTH));
	assign push        = wr.wen & ~full;  // overflow drops the word
	assign pop         = ren & nempty;
	assign nempty      = (count != '0);
	assign nearly_full = (count >= (PTR_W+1)'(FIFO_NEARLY_FULL));
	assign q           = mem[rd_ptr];  // head word, show-ahead

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + PTR_W'(1);  // wraps at depth
			end
			if (pop) begin
				rd_ptr <= rd_ptr + PTR_W'(1);
			end
			case ({push, pop})
				2'b10:   count <= count + (PTR_W+1)'(1);
				2'b01:   count <= count - (PTR_W+1)'(1);
				default: count <= count;  // both or neither
			endcase
		end
	end

endmodule

//--- hdl/dynode_readout.sv
// ####################
// dynode trigger readout top
// upstream detection and energy arrive as inputs
// cfg is static while a frame is built
// fifo has no back-pressure, overflow loses words
// ####################
module dynode_readout (
	input  logic                           clk,
	input  logic                           rst,
	input  dyn_trg_pkg::adc_in_t           adc,
	input  dyn_trg_pkg::event_in_t         evt,
	input  dyn_trg_pkg::energy_in_t        energy,
	input  logic                           trigger,
	input  dyn_trg_pkg::readout_cfg_t      cfg,
	input  logic                           fifo_ren,
	output logic [7:0]                     trigger_code,
	output logic [dyn_trg_pkg::WORD_W-1:0] fifo_q,
	output logic                           fifo_ne,
	output logic                           fifo_nearly_full
);
	import dyn_trg_pkg::*;

	logic [WORD_W-1:0] sample_word;  // delayed sample to framer
	logic [WORD_W-1:0] energy_word;  // latched energy to framer
	logic              frame_start;
	logic              frame_busy;
	fifo_wr_t          wr;           // framer write port

	sample_delay sample_delay_i (
		.clk         (clk),
		.adc         (adc),
		.mode        (cfg.mode),
		.tap         (cfg.tap),
		.sample_word (sample_word)
	);

	event_capture event_capture_i (
		.clk          (clk),
		.rst          (rst),
		.evt          (evt),
		.energy       (energy),
		.trigger      (trigger),
		.frame_busy   (frame_busy),
		.trigger_code (trigger_code),
		.frame_start  (frame_start),
		.energy_word  (energy_word)
	);

	frame_builder frame_builder_i (
		.clk         (clk),
		.rst         (rst),
		.frame_start (frame_start),
		.cfg         (cfg),
		.sample_word (sample_word),
		.energy_word (energy_word),
		.frame_busy  (frame_busy),
		.wr          (wr)
	);

	trigger_fifo trigger_fifo_i (
		.clk         (clk),
		.rst         (rst),
		.wr          (wr),
		.ren         (fifo_ren),
		.q           (fifo_q),
		.nempty      (fifo_ne),
		.nearly_full (fifo_nearly_full)
	);

endmodule

//--- tb/dynode_readout_assertions.sv
// ####################
// framer and fifo properties, bound into both blocks
// ports a binding does not use are tied inactive
// ####################
module dynode_readout_assertions (
	input logic                        clk,
	input logic                        rst,
	input dyn_trg_pkg::frame_state_e   state,
	input logic                        wen,
	input logic                        frame_start,
	input logic                        frame_busy,
	input logic                        nempty,
	input logic [dyn_trg_pkg::PTR_W:0] count
);
	timeunit 1ns;
	timeprecision 1ps;
	import dyn_trg_pkg::*;

	idle_no_write: assert property (@(posedge clk) disable iff (rst)
		(state == ST_IDLE) |-> !wen)
		else $error("fifo write strobe high while the framer is idle");

	// a wrapped count would show data that was never written
	nempty_count_valid: assert property (@(posedge clk) disable iff (rst)
		nempty |-> (count <= (PTR_W+1)'(FIFO_DEPTH)))
		else $error("fifo reports data with a word count beyond its depth");

	// a second start would be lost inside a running frame
	no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
		!(frame_start && frame_busy))
		else $error("frame start strobe while a frame is running");

endmodule

bind frame_builder dynode_readout_assertions frame_chk_i (
	.clk         (clk),
	.rst         (rst),
	.state       (state),
	.wen         (wr.wen),
	.frame_start (frame_start),
	.frame_busy  (frame_busy),
	.nempty      (1'b0),
	.count       ('0)
);

bind trigger_fifo dynode_readout_assertions fifo_chk_i (
	.clk         (clk),
	.rst         (rst),
	.state       (dyn_trg_pkg::ST_IDLE),
	.wen         (1'b0),
	.frame_start (1'b0),
	.frame_busy  (1'b0),
	.nempty      (nempty),
	.count       (count)
);

//--- tb/dynode_readout_tb.sv
// ####################
// testbench for the dynode readout channel
// adc is a free-running ramp, one step per clock
// expected records come from the frame timing rules
// fifo drained after each record, overflow test excepted
// ####################
module dynode_readout_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import dyn_trg_pkg::*;

	localparam int          N_ROWS     = 10;
	localparam int          TIMEOUT_NS = (N_ROWS + 2) * 200 * 100;  // overflow frames as 2 rows
	localparam int          SETTLE     = 32;  // refill delay line after a cfg change
	localparam int          POP_WAIT   = 64;  // clocks allowed for a record word
	localparam int          FIRST_DATA = 6;   // start strobe to first sample write
	localparam logic [31:0] SEED       = 32'h6d7;

	typedef struct packed {
		data_mode_e        mode;
		logic [1:0]        channel;
		logic [3:0]        tap;
		logic              use_trigger;  // external trigger instead of energy load
		logic [CORR_W-1:0] energy;
		logic              flag;
		logic [TIME_W-1:0] etime;
		logic [7:0]        exp_code;
	} stim_row_t;

	logic              clk;
	logic              rst;
	adc_in_t           adc;
	event_in_t         evt;
	energy_in_t        energy;
	logic              trigger;
	readout_cfg_t      cfg;
	logic              fifo_ren;
	logic [7:0]        trigger_code;
	logic [WORD_W-1:0] fifo_q;
	logic              fifo_ne;
	logic              fifo_nearly_full;

	int                cycle_cnt = 0;  // rising edges seen
	logic [CORR_W-1:0] ramp_base;
	logic [CORR_W-1:0] last_energy;    // what the dut latch should hold
	logic [CORR_W-1:0] lag_diff;
	logic [WORD_W-1:0] exp_q [$];
	logic [WORD_W-1:0] got_q [$];
	stim_row_t         rows [N_ROWS];
	logic [WORD_W-1:0] first_sample [N_ROWS];
	int                start_cycle [N_ROWS];
	int                value_errors = 0;
	int                other_errors = 0;

	dynode_readout dynode_readout_i (
		.clk              (clk),
		.rst              (rst),
		.adc              (adc),
		.evt              (evt),
		.energy           (energy),
		.trigger          (trigger),
		.cfg              (cfg),
		.fifo_ren         (fifo_ren),
		.trigger_code     (trigger_code),
		.fifo_q           (fifo_q),
		.fifo_ne          (fifo_ne),
		.fifo_nearly_full (fifo_nearly_full)
	);

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [CORR_W-1:0] ramp_at(int c);
		return ramp_base + CORR_W'(c);  // value driven in cycle c
	endfunction

	// words after the mask, samples plus energy
	function automatic int record_words(data_mode_e mode);
		case (mode)
			MODE_ENERGY:     return 1;
			MODE_CORR_SHORT: return 17;
			default:         return 33;  // raw and long corrected
		endcase
	endfunction

	function automatic void build_frame(readout_cfg_t c, int s, logic [CORR_W-1:0] e);
		int                n;
		int                age;
		logic [CORR_W-1:0] smp;
		logic [WORD_W-1:0] mask;
		n    = record_words(c.mode);
		age  = SAMPLE_FIX_DELAY + int'(c.tap) + 2;  // sample age at its write
		mask = '0;
		mask[c.channel] = 1'b1;
		exp_q.push_back(PREAMBLE);
		exp_q.push_back(WORD_W'(n));
		exp_q.push_back(mask);
		for (int k = 0; k < n - 1; k++) begin
			smp = ramp_at(s + FIRST_DATA + k - age);
			if (c.mode == MODE_RAW) begin
				exp_q.push_back({{(WORD_W-ADC_W){1'b0}}, smp[ADC_W-1:0]});
			end else begin
				exp_q.push_back({{(WORD_W-CORR_W){1'b0}}, smp});
			end
		end
		exp_q.push_back({{(WORD_W-CORR_W){1'b0}}, e});  // closing energy word
	endfunction

	task automatic check_word(logic [WORD_W-1:0] got, logic [WORD_W-1:0] exp, string what);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_code(logic [7:0] got, logic [7:0] exp, string what);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(logic got, logic exp, string what);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic wait_until(int c);
		while (cycle_cnt < c) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic pop_word(output logic [WORD_W-1:0] w, output bit ok);
		int waited;
		waited = 0;
		ok     = 1'b0;
		w      = '0;
		while (!fifo_ne && waited < POP_WAIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (fifo_ne) begin
			w        = fifo_q;  // show-ahead head word
			fifo_ren = 1'b1;
			@(posedge clk);
			#1;
			fifo_ren = 1'b0;
			ok       = 1'b1;
		end else begin
			other_errors++;
			$display("ERROR at %0t: fifo stayed empty while a record word was due", $time);
		end
	endtask

	task automatic read_frame(int n, string tag);
		logic [WORD_W-1:0] w;
		bit                ok;
		got_q.delete();
		for (int k = 0; k < n; k++) begin
			pop_word(w, ok);
			if (!ok) begin
				return;
			end
			got_q.push_back(w);
			check_word(w, exp_q[k], $sformatf("%s word %0d", tag, k));
		end
	endtask

	// strobe, event and code checks, two clocks long
	task automatic start_record(stim_row_t r, output int s);
		s = cycle_cnt;
		if (r.use_trigger) begin
			trigger = 1'b1;
		end else begin
			energy.load  = 1'b1;
			energy.value = r.energy;
			last_energy  = r.energy;
		end
		evt.flag  = r.flag;
		evt.etime = r.etime;
		build_frame(cfg, s, last_energy);
		@(posedge clk);
		#1;
		trigger     = 1'b0;
		energy.load = 1'b0;
		evt.flag    = 1'b0;
		check_code(trigger_code, r.exp_code, $sformatf("trigger code for time %h", r.etime));
		@(posedge clk);
		#1;
		check_code(trigger_code, TRIG_IDLE_CODE, "idle code after event");
	endtask

	task automatic run_row(int i);
		stim_row_t r;
		int        s;
		r   = rows[i];
		cfg = '{mode: r.mode, channel: r.channel, tap: r.tap};
		exp_q.delete();
		repeat (SETTLE) @(posedge clk);
		#1;
		start_record(r, s);
		read_frame(record_words(r.mode) + 3, $sformatf("row %0d", i));
		check_flag(fifo_ne, 1'b0, $sformatf("row %0d fifo empty after record", i));
		start_cycle[i]  = s;
		first_sample[i] = (got_q.size() > 3) ? got_q[3] : '0;
	endtask

	// two raw records, no reads, second one truncated
	task automatic overflow_test();
		stim_row_t r;
		int        s;
		cfg = '{mode: MODE_RAW, channel: 2'd2, tap: 4'd5};
		exp_q.delete();
		repeat (SETTLE) @(posedge clk);
		#1;
		r = '{MODE_RAW, 2'd2, 4'd5, 1'b0, 12'h1C3, 1'b0, 24'h000000, TRIG_IDLE_CODE};
		start_record(r, s);
		wait_until(s + FIRST_DATA + record_words(MODE_RAW) + 1);
		check_flag(fifo_ne, 1'b1, "fifo holds first raw record");
		check_flag(fifo_nearly_full, 1'b0, "nearly full after one raw record");
		r.energy = 12'h6E9;
		start_record(r, s);
		wait_until(s + FIRST_DATA + record_words(MODE_RAW) + 1);
		check_flag(fifo_nearly_full, 1'b1, "nearly full after two raw records");
		read_frame(FIFO_DEPTH, "overflow");
		check_flag(fifo_ne, 1'b0, "fifo empty after overflow readout");
	endtask

	function automatic void load_table();
		rows[0] = '{MODE_ENERGY, 2'd0, 4'd0, 1'b0, 12'h3A1, 1'b1, 24'h000123, 8'h12};
		rows[1] = '{MODE_ENERGY, 2'd1, 4'd0, 1'b0, 12'h055, 1'b1, 24'h000FC0, 8'hF8};
		rows[2] = '{MODE_ENERGY, 2'd2, 4'd0, 1'b0, 12'hFFF, 1'b0, 24'h000456, 8'hFF};
		rows[3] = '{MODE_ENERGY, 2'd3, 4'd0, 1'b1, 12'h000, 1'b1, 24'h0AB7F0, 8'h7F};
		rows[4] = '{MODE_RAW, 2'd1, 4'd0, 1'b0, 12'h812, 1'b1, 24'h123FFF, 8'hF8};
		rows[5] = '{MODE_CORR_LONG, 2'd2, 4'd3, 1'b0, 12'h0C4, 1'b1, 24'h000BC5, 8'hBC};
		rows[6] = '{MODE_CORR_SHORT, 2'd3, 4'd15, 1'b1, 12'h000, 1'b1, 24'h000F90, 8'hF9};
		rows[7] = '{MODE_CORR_SHORT, 2'd0, 4'd0, 1'b0, 12'h7E7, 1'b0, 24'h000FFF, 8'hFF};
		rows[8] = '{MODE_CORR_LONG, 2'd1, 4'd0, 1'b0, 12'h2B0, 1'b1, 24'h000010, 8'h01};
		rows[9] = '{MODE_CORR_LONG, 2'd1, 4'd9, 1'b1, 12'h000, 1'b1, 24'h00FF3F, 8'hF3};
	endfunction

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	initial begin
		ramp_base = CORR_W'(xorshift32(SEED));
		adc       = '0;
		forever begin
			@(posedge clk);
			#1;
			adc.corr = ramp_at(cycle_cnt);
			adc.raw  = adc.corr[ADC_W-1:0];  // raw follows the low byte
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog: run still going after %0d ns, stimulus or dut is stuck", TIMEOUT_NS);
		$display("Checks failed");
		$finish;
	end

	initial begin
		rst         = 1'b1;
		evt         = '0;
		energy      = '0;
		trigger     = 1'b0;
		cfg         = '{mode: MODE_ENERGY, channel: 2'd0, tap: 4'd0};
		fifo_ren    = 1'b0;
		last_energy = '0;
		load_table();
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		check_code(trigger_code, TRIG_IDLE_CODE, "trigger code after reset");
		check_flag(fifo_ne, 1'b0, "fifo empty after reset");
		check_flag(fifo_nearly_full, 1'b0, "nearly full low after reset");
		for (int i = 0; i < N_ROWS; i++) begin
			run_row(i);
		end
		// rows 8 and 9 differ only in tap
		lag_diff = (ramp_at(start_cycle[9]) - first_sample[9][CORR_W-1:0])
			- (ramp_at(start_cycle[8]) - first_sample[8][CORR_W-1:0]);
		check_word({{(WORD_W-CORR_W){1'b0}}, lag_diff}, WORD_W'(9), "tap 9 lag over tap 0");
		overflow_test();
		$display("summary: %0d value mismatches, %0d other errors", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- files.f
hdl/dyn_trg_pkg.sv
hdl/sample_delay.sv
hdl/event_capture.sv
hdl/frame_builder.sv
hdl/trigger_fifo.sv
hdl/dynode_readout.sv
tb/dynode_readout_assertions.sv
tb/dynode_readout_tb.sv

//--- Makefile
TOP  = dynode_readout_tb
SRCS = $(shell cat files.f)

obj_dir/V$(TOP): files.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^All checks passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
